/* design/tmr_pkg.sv */
// Shared types, register map and bus structs, imported by every block of the TMR lockstep controller
package tmr_pkg;

  localparam int unsigned NumCores = 3;

  // Result word, mismatch counter and register bus widths
  typedef logic [31:0]         core_data_t;
  typedef logic [NumCores-1:0] core_mask_t;
  typedef logic [15:0]         mm_cnt_t;
  typedef logic [7:0]          axi_addr_t;
  typedef logic [31:0]         axi_data_t;
  typedef logic [3:0]          axi_strb_t;
  typedef logic [1:0]          axi_resp_t;

  // Redundancy modes of the group
  typedef enum logic [2:0] {
    MODE_INDEP,
    MODE_RUN,
    MODE_UNLOAD,
    MODE_RELOAD,
    MODE_RAPID
  } tmr_mode_e;

  // Rapid recovery hardware present
  localparam bit RapidRecovery = 1'b1;

  localparam axi_addr_t AddrCtrl   = 8'h00;
  localparam axi_addr_t AddrStatus = 8'h04;
  localparam axi_addr_t AddrCnt0   = 8'h08;
  localparam axi_addr_t AddrCnt1   = 8'h0C;
  localparam axi_addr_t AddrCnt2   = 8'h10;

  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespSlverr = 2'b10;

  // Control register with enable in bit 0
  typedef struct packed {
    logic force_resynch;
    logic rapid_recovery;
    logic reload_setback;
    logic setback_en;
    logic delay_resynch;
    logic enable;
  } tmr_cfg_t;

  typedef struct packed {
    core_data_t [NumCores-1:0] data;
  } core_res_t;

  typedef struct packed {
    core_data_t voted;
    logic       single_mismatch;
    core_mask_t err;
    logic       failure;
  } vote_t;

  typedef struct packed {
    logic      awvalid;
    axi_addr_t awaddr;
    logic      wvalid;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      bready;
    logic      arvalid;
    axi_addr_t araddr;
    logic      rready;
  } axi_req_t;

  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    axi_resp_t bresp;
    logic      arready;
    logic      rvalid;
    axi_data_t rdata;
    axi_resp_t rresp;
  } axi_rsp_t;

endpackage

/* design/tmr_voter.sv */
`timescale 1ns/1ps
// Majority voter that compares the three core results each cycle and flags the odd core out
module tmr_voter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tmr_pkg::core_res_t core_res_i,
  output tmr_pkg::vote_t     vote_o
);
  import tmr_pkg::*;

  core_data_t maj;
  core_mask_t err;
  logic       fail;
  vote_t      vote_d;
  vote_t      vote_q;

  always_comb begin : proc_vote
    // Bitwise two-of-three majority
    maj = (core_res_i.data[0] & core_res_i.data[1]) |
          (core_res_i.data[0] & core_res_i.data[2]) |
          (core_res_i.data[1] & core_res_i.data[2]);
    for (int i = 0; i < NumCores; i++) begin
      err[i] = (core_res_i.data[i] != maj);
    end
    // No pair of cores agrees
    fail = (core_res_i.data[0] != core_res_i.data[1]) &&
           (core_res_i.data[0] != core_res_i.data[2]) &&
           (core_res_i.data[1] != core_res_i.data[2]);
    vote_d.voted           = maj;
    vote_d.err             = err;
    vote_d.failure         = fail;
    // Exactly one core off the majority
    vote_d.single_mismatch = $onehot(err);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_vote_q
    if (!rst_ni) begin
      vote_q <= '0;
    end else begin
      vote_q <= vote_d;
    end
  end

  assign vote_o = vote_q;

  // A failure is never also reported as a correctable mismatch
  a_no_dual_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(vote_q.single_mismatch && vote_q.failure));

endmodule

/* design/tmr_regs.sv */
`timescale 1ns/1ps
// AXI4-Lite register file with the control word, mode status and per-core mismatch counters
module tmr_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tmr_pkg::axi_req_t   axi_req_i,
  output tmr_pkg::axi_rsp_t   axi_rsp_o,
  output tmr_pkg::tmr_cfg_t   cfg_o,
  input  tmr_pkg::tmr_mode_e  mode_i,
  input  tmr_pkg::core_mask_t incr_mm_i,
  input  logic                force_ack_i
);
  import tmr_pkg::*;

  logic       wr_fire;
  logic       rd_fire;
  logic       wr_ctrl;
  logic       wr_known;
  core_mask_t wr_cnt;
  axi_data_t  rd_data;
  axi_resp_t  rd_resp;

  logic       bvalid_q;
  axi_resp_t  bresp_q;
  logic       rvalid_q;
  axi_resp_t  rresp_q;
  axi_data_t  rdata_q;
  tmr_cfg_t   cfg_q;
  mm_cnt_t    cnt_q [NumCores];

  // One write and one read in flight at most
  assign wr_fire = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axi_req_i.arvalid & ~rvalid_q;

  always_comb begin : proc_wr_decode
    wr_ctrl  = 1'b0;
    wr_cnt   = '0;
    wr_known = 1'b1;
    case (axi_req_i.awaddr)
      AddrCtrl:   wr_ctrl   = wr_fire & axi_req_i.wstrb[0];
      // Status is read only
      AddrStatus: wr_known  = 1'b1;
      AddrCnt0:   wr_cnt[0] = wr_fire & (|axi_req_i.wstrb);
      AddrCnt1:   wr_cnt[1] = wr_fire & (|axi_req_i.wstrb);
      AddrCnt2:   wr_cnt[2] = wr_fire & (|axi_req_i.wstrb);
      default:    wr_known  = 1'b0;
    endcase
  end

  always_comb begin : proc_rd_decode
    rd_data = '0;
    rd_resp = RespOkay;
    case (axi_req_i.araddr)
      AddrCtrl:   rd_data = axi_data_t'(cfg_q);
      AddrStatus: rd_data = axi_data_t'(mode_i);
      AddrCnt0:   rd_data = axi_data_t'(cnt_q[0]);
      AddrCnt1:   rd_data = axi_data_t'(cnt_q[1]);
      AddrCnt2:   rd_data = axi_data_t'(cnt_q[2]);
      default:    rd_resp = RespSlverr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_bus
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RespOkay;
      rvalid_q <= 1'b0;
      rresp_q  <= RespOkay;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_known ? RespOkay : RespSlverr;
      end else if (axi_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_resp;
      end else if (axi_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_rdata
    if (rd_fire) begin
      rdata_q <= rd_data;
    end
  end

  // Bus write beats the controller's acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cfg
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_ctrl) begin
      cfg_q <= tmr_cfg_t'(axi_req_i.wdata[$bits(tmr_cfg_t)-1:0]);
    end else if (force_ack_i) begin
      cfg_q.force_resynch <= 1'b0;
    end
  end

  for (genvar i = 0; i < NumCores; i++) begin : gen_cnt
    // Saturating counter that any write to its address clears
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cnt
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (wr_cnt[i]) begin
        cnt_q[i] <= '0;
      end else if (incr_mm_i[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  always_comb begin : proc_rsp
    axi_rsp_o.awready = wr_fire;
    axi_rsp_o.wready  = wr_fire;
    axi_rsp_o.bvalid  = bvalid_q;
    axi_rsp_o.bresp   = bresp_q;
    axi_rsp_o.arready = rd_fire;
    axi_rsp_o.rvalid  = rvalid_q;
    axi_rsp_o.rdata   = rdata_q;
    axi_rsp_o.rresp   = rresp_q;
  end

  assign cfg_o = cfg_q;

  // Write response and its code hold until the master takes them
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_q && !axi_req_i.bready |=> bvalid_q && $stable(bresp_q));

endmodule

/* design/tmr_mode_ctrl.sv */
`timescale 1ns/1ps
// Redundancy mode FSM of the core group, driving setback, synch and recovery requests
module tmr_mode_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tmr_pkg::tmr_cfg_t   cfg_i,
  input  tmr_pkg::vote_t      vote_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  input  logic                unload_done_i,
  input  logic                reload_done_i,
  input  logic                recovery_finished_i,
  output tmr_pkg::tmr_mode_e  mode_o,
  output tmr_pkg::core_mask_t incr_mm_o,
  output logic                force_ack_o,
  output tmr_pkg::core_mask_t setback_o,
  output logic                sw_synch_req_o,
  output logic                sw_resynch_req_o,
  output logic                recovery_request_o,
  output logic                grp_independent_o,
  output logic                rapid_recovery_en_o
);
  import tmr_pkg::*;

  tmr_mode_e mode_d;
  tmr_mode_e mode_q;
  logic      synch_req;
  logic      synch_req_q;
  logic      resynch_req;
  logic      resynch_req_q;
  logic      cores_synch_q;
  logic      rapid_en;

  assign rapid_en            = cfg_i.rapid_recovery & RapidRecovery;
  assign rapid_recovery_en_o = rapid_en;
  assign grp_independent_o   = (mode_q == MODE_INDEP);
  assign mode_o              = mode_q;

  // Level requests turned into single pulses on their rising edge
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  always_comb begin : proc_fsm
    mode_d             = mode_q;
    setback_o          = '0;
    incr_mm_o          = '0;
    force_ack_o        = 1'b0;
    recovery_request_o = 1'b0;
    synch_req          = 1'b0;
    resynch_req        = 1'b0;

    case (mode_q)
      MODE_RUN: begin
        force_ack_o = cfg_i.force_resynch;
        if (vote_i.single_mismatch) begin
          incr_mm_o = vote_i.err;
        end
        if (cfg_i.force_resynch || vote_i.single_mismatch) begin
          if (rapid_en) begin
            mode_d = MODE_RAPID;
          end else if (!cfg_i.delay_resynch) begin
            mode_d = MODE_UNLOAD;
          end
        end
      end
      MODE_UNLOAD: begin
        resynch_req = 1'b1;
        if (unload_done_i) begin
          mode_d = MODE_RELOAD;
          if (cfg_i.setback_en) begin
            setback_o = 3'b111;
          end
        end
      end
      MODE_RELOAD: begin
        if (reload_done_i) begin
          mode_d = MODE_RUN;
        end else if ((vote_i.single_mismatch || vote_i.failure) &&
                     cfg_i.setback_en && cfg_i.reload_setback) begin
          // Restart the reload if the cores diverge again
          setback_o = 3'b111;
        end
      end
      MODE_RAPID: begin
        recovery_request_o = 1'b1;
        if (recovery_finished_i) begin
          mode_d = MODE_RUN;
        end
      end
      default: ;
    endcase

    // Enter lockstep once the cores report they are synchronised
    if (mode_q == MODE_INDEP && cfg_i.enable) begin
      synch_req = 1'b1;
      if (cores_synch_q) begin
        if (rapid_en) begin
          mode_d = MODE_RAPID;
        end else begin
          mode_d = MODE_RELOAD;
          if (cfg_i.setback_en) begin
            setback_o = 3'b111;
          end
        end
      end
    end

    // Before the cores fetch, the mode simply follows enable
    if (!fetch_en_i) begin
      if (cfg_i.enable) begin
        mode_d    = MODE_RUN;
        synch_req = 1'b0;
      end else begin
        mode_d = MODE_INDEP;
      end
    end

    // Split back to independent cores while core 0 keeps running
    if (mode_q == MODE_RUN && !cfg_i.enable) begin
      mode_d = MODE_INDEP;
      if (cfg_i.setback_en) begin
        setback_o = 3'b110;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_mode
    if (!rst_ni) begin
      mode_q        <= MODE_INDEP;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
      cores_synch_q <= cores_synch_i;
    end
  end

  a_mode_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode_q inside {MODE_INDEP, MODE_RUN, MODE_UNLOAD, MODE_RELOAD, MODE_RAPID});

endmodule

/* design/tmr_lockstep_top.sv */
`timescale 1ns/1ps
// Lockstep controller top for one core triple, connecting voter, AXI4-Lite registers and mode FSM
module tmr_lockstep_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Register bus
  input  tmr_pkg::axi_req_t   axi_req_i,
  output tmr_pkg::axi_rsp_t   axi_rsp_o,
  // Core results and core status
  input  tmr_pkg::core_res_t  core_res_i,
  input  logic                fetch_en_i,
  input  logic                cores_synch_i,
  input  logic                unload_done_i,
  input  logic                reload_done_i,
  input  logic                recovery_finished_i,
  // Voted result and requests to the cores
  output tmr_pkg::core_data_t voted_o,
  output tmr_pkg::core_mask_t setback_o,
  output logic                sw_synch_req_o,
  output logic                sw_resynch_req_o,
  output logic                recovery_request_o,
  output logic                grp_independent_o,
  output logic                rapid_recovery_en_o
);
  import tmr_pkg::*;

  vote_t      vote;
  tmr_cfg_t   cfg;
  tmr_mode_e  mode;
  core_mask_t incr_mm;
  logic       force_ack;

  tmr_voter tmr_voter_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .core_res_i (core_res_i),
    .vote_o     (vote)
  );

  assign voted_o = vote.voted;

  tmr_regs tmr_regs_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .axi_req_i   (axi_req_i),
    .axi_rsp_o   (axi_rsp_o),
    .cfg_o       (cfg),
    .mode_i      (mode),
    .incr_mm_i   (incr_mm),
    .force_ack_i (force_ack)
  );

  tmr_mode_ctrl tmr_mode_ctrl_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .cfg_i               (cfg),
    .vote_i              (vote),
    .fetch_en_i          (fetch_en_i),
    .cores_synch_i       (cores_synch_i),
    .unload_done_i       (unload_done_i),
    .reload_done_i       (reload_done_i),
    .recovery_finished_i (recovery_finished_i),
    .mode_o              (mode),
    .incr_mm_o           (incr_mm),
    .force_ack_o         (force_ack),
    .setback_o           (setback_o),
    .sw_synch_req_o      (sw_synch_req_o),
    .sw_resynch_req_o    (sw_resynch_req_o),
    .recovery_request_o  (recovery_request_o),
    .grp_independent_o   (grp_independent_o),
    .rapid_recovery_en_o (rapid_recovery_en_o)
  );

endmodule

/* sim/tmr_lockstep_tb.sv */
`timescale 1ns/1ps
// Trace-driven testbench that runs the TMR lockstep controller from the project root with the file list
module tmr_lockstep_tb;
  import tmr_pkg::*;

  localparam int unsigned WaitLimit  = 200;
  localparam int unsigned ReadyDelay = 3;

  logic       clk_i;
  logic       rst_ni;
  axi_req_t   axi_req;
  axi_rsp_t   axi_rsp;
  core_res_t  core_res;
  logic       fetch_en;
  logic       cores_synch;
  logic       unload_done;
  logic       reload_done;
  logic       recovery_finished;
  core_data_t voted;
  core_mask_t setback;
  logic       sw_synch_req;
  logic       sw_resynch_req;
  logic       recovery_request;
  logic       grp_independent;
  logic       rapid_recovery_en;

  integer     seed;
  int         value_errs = 0;
  int         other_errs = 0;
  bit         abort = 1'b0;
  int         cycles = 0;
  int         synch_cnt = 0;
  int         resynch_cnt = 0;
  int         setback_cnt = 0;
  core_mask_t setback_last = '0;
  int         synch_mark = 0;
  int         resynch_mark = 0;
  int         setback_mark = 0;
  axi_data_t  ctrl_written = '0;

  tmr_lockstep_top tmr_lockstep_top_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .axi_req_i           (axi_req),
    .axi_rsp_o           (axi_rsp),
    .core_res_i          (core_res),
    .fetch_en_i          (fetch_en),
    .cores_synch_i       (cores_synch),
    .unload_done_i       (unload_done),
    .reload_done_i       (reload_done),
    .recovery_finished_i (recovery_finished),
    .voted_o             (voted),
    .setback_o           (setback),
    .sw_synch_req_o      (sw_synch_req),
    .sw_resynch_req_o    (sw_resynch_req),
    .recovery_request_o  (recovery_request),
    .grp_independent_o   (grp_independent),
    .rapid_recovery_en_o (rapid_recovery_en)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Counts the one-cycle request pulses and setbacks between mode checks
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rst_ni) begin
      synch_cnt   <= synch_cnt + int'(sw_synch_req);
      resynch_cnt <= resynch_cnt + int'(sw_resynch_req);
      if (setback != '0) begin
        setback_cnt  <= setback_cnt + 1;
        setback_last <= setback;
      end
    end
  end

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_core(input string name, input core_data_t exp, input core_data_t got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_mode(input string name, input tmr_mode_e exp, input tmr_mode_e got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t exp, input core_mask_t got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    if (got != exp) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
      value_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, WaitLimit);
    other_errs++;
    abort = 1'b1;
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
    int n;
    @(posedge clk_i);
    axi_req.awvalid <= 1'b1;
    axi_req.awaddr  <= addr;
    axi_req.wvalid  <= 1'b1;
    axi_req.wdata   <= data;
    axi_req.wstrb   <= 4'hf;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axi_rsp.awready && n < WaitLimit);
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    axi_req.bready  <= 1'b1;
    if (!axi_rsp.awready) begin
      report_timeout("write address and data handshake");
      return;
    end
    check_flag("wready", 1'b1, axi_rsp.wready);
    if (addr == AddrCtrl) begin
      ctrl_written = data;
    end
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axi_rsp.bvalid && n < WaitLimit);
    axi_req.bready <= 1'b0;
    if (!axi_rsp.bvalid) begin
      report_timeout("write response");
    end else begin
      check_resp("bresp", RespOkay, axi_rsp.bresp);
    end
  endtask

  // Read with rready held back, so the response has to wait on the bus
  task automatic axi_read(input axi_addr_t addr, output axi_data_t data, output axi_resp_t resp);
    int n;
    data = '0;
    resp = '0;
    @(posedge clk_i);
    axi_req.arvalid <= 1'b1;
    axi_req.araddr  <= addr;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axi_rsp.arready && n < WaitLimit);
    axi_req.arvalid <= 1'b0;
    if (!axi_rsp.arready) begin
      report_timeout("read address handshake");
      return;
    end
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axi_rsp.rvalid && n < WaitLimit);
    if (!axi_rsp.rvalid) begin
      report_timeout("read response");
      return;
    end
    repeat (ReadyDelay) @(posedge clk_i);
    check_flag("rvalid", 1'b1, axi_rsp.rvalid);
    axi_req.rready <= 1'b1;
    @(posedge clk_i);
    data = axi_rsp.rdata;
    resp = axi_rsp.rresp;
    axi_req.rready <= 1'b0;
  endtask

  // One cycle of core words, then all cores agree on the expected word again
  task automatic vote_cores(input bit use_rnd, input core_data_t w0, input core_data_t w1,
                            input core_data_t w2, input core_data_t wv);
    core_data_t base;
    base = use_rnd ? core_data_t'($random(seed)) : '0;
    @(posedge clk_i);
    core_res.data[0] <= base ^ w0;
    core_res.data[1] <= base ^ w1;
    core_res.data[2] <= base ^ w2;
    @(posedge clk_i);
    core_res.data[0] <= base ^ wv;
    core_res.data[1] <= base ^ wv;
    core_res.data[2] <= base ^ wv;
    @(posedge clk_i);
    check_core("voted_o", base ^ wv, voted);
  endtask

  task automatic drive_pins(input int fe, input int cs, input int ud, input int rd, input int rf);
    @(posedge clk_i);
    fetch_en          <= fe[0];
    cores_synch       <= cs[0];
    unload_done       <= ud[0];
    reload_done       <= rd[0];
    recovery_finished <= rf[0];
  endtask

  // Polls STATUS until the mode is reached, then checks the pulses seen since the last poll
  task automatic expect_mode(input tmr_mode_e exp_mode, input core_mask_t exp_sb,
                             input int exp_synch, input int exp_resynch);
    axi_data_t d;
    axi_resp_t r;
    int        start;
    start = cycles;
    do begin
      axi_read(AddrStatus, d, r);
    end while (!abort && d[2:0] != exp_mode && cycles - start < WaitLimit);
    if (abort) begin
      return;
    end
    check_mode("mode", exp_mode, tmr_mode_e'(d[2:0]));
    if (d[2:0] != exp_mode) begin
      report_timeout("mode change");
      return;
    end
    check_flag("grp_independent_o", exp_mode == MODE_INDEP, grp_independent);
    check_flag("recovery_request_o", exp_mode == MODE_RAPID, recovery_request);
    check_flag("rapid_recovery_en_o", ctrl_written[4] & RapidRecovery, rapid_recovery_en);
    check_count("sw_synch_req_o pulses", exp_synch, synch_cnt - synch_mark);
    check_count("sw_resynch_req_o pulses", exp_resynch, resynch_cnt - resynch_mark);
    check_count("setback_o pulses", (exp_sb != '0) ? 1 : 0, setback_cnt - setback_mark);
    if (exp_sb != '0) begin
      check_mask("setback_o", exp_sb, setback_last);
    end
    synch_mark   = synch_cnt;
    resynch_mark = resynch_cnt;
    setback_mark = setback_cnt;
  endtask

  initial begin
    int                fd;
    int                op;
    int                n;
    int                flag;
    int                p0;
    int                p1;
    int                p2;
    int                p3;
    int                p4;
    axi_addr_t         addr;
    axi_data_t         data;
    axi_data_t         got_data;
    axi_resp_t         resp;
    axi_resp_t         got_resp;
    core_data_t        w0;
    core_data_t        w1;
    core_data_t        w2;
    core_data_t        wv;
    logic [8*256-1:0]  skip;
    seed              = 31297;
    rst_ni            = 1'b0;
    axi_req           = '0;
    core_res          = '0;
    fetch_en          = 1'b0;
    cores_synch       = 1'b0;
    unload_done       = 1'b0;
    reload_done       = 1'b0;
    recovery_finished = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    fd = $fopen("sim/tmr_lockstep_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/tmr_lockstep_trace.txt");
      other_errs++;
      abort = 1'b1;
    end
    while (!abort && $fscanf(fd, " %c", op) == 1) begin
      case (op)
        "#": begin
          n = $fgets(skip, fd);
        end
        "W": begin
          n = $fscanf(fd, "%h %h", addr, data);
          axi_write(addr, data);
        end
        "R": begin
          n = $fscanf(fd, "%h %h %h", addr, data, resp);
          axi_read(addr, got_data, got_resp);
          if (!abort) begin
            check_data("rdata", data, got_data);
            check_resp("rresp", resp, got_resp);
          end
        end
        "C": begin
          n = $fscanf(fd, "%h %h %h %h %h", flag, w0, w1, w2, wv);
          vote_cores(flag != 0, w0, w1, w2, wv);
        end
        "S": begin
          n = $fscanf(fd, "%h %h %h %h %h", p0, p1, p2, p3, p4);
          drive_pins(p0, p1, p2, p3, p4);
        end
        "M": begin
          n = $fscanf(fd, "%h %h %h %h", p0, p1, p2, p3);
          expect_mode(tmr_mode_e'(p0), core_mask_t'(p1), p2, p3);
        end
        default: begin
          $display("Unknown operation code %c in the trace file", op);
          other_errs++;
          abort = 1'b1;
        end
      endcase
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tmr_lockstep.f */
design/tmr_pkg.sv
design/tmr_voter.sv
design/tmr_regs.sv
design/tmr_mode_ctrl.sv
design/tmr_lockstep_top.sv
sim/tmr_lockstep_tb.sv

/* sim/tmr_lockstep_trace.txt */
# W addr data | R addr exp_data exp_resp | S fetch_en cores_synch unload_done reload_done rec_done
# C rnd w0 w1 w2 exp_voted (rnd 1 xors all four with a random word) | M mode setback synch resynch
R 04 00000000 0
W 00 0000000E
R 00 0000000E 0
R 20 00000000 2
W 00 00000003
M 1 0 0 0
C 0 11111111 11111111 2222EEEE 11111111
R 10 00000001 0
C 1 00000400 00000000 00000000 00000000
R 08 00000001 0
W 10 00000000
R 10 00000000 0
M 1 0 0 0
W 00 00000000
M 0 0 0 0
# Enter lockstep through the synch handshake and a reload
S 1 0 0 0 0
W 00 00000005
M 0 0 1 0
S 1 1 0 0 0
M 3 7 0 0
S 1 0 0 1 0
M 1 0 0 0
S 1 0 0 0 0
# Resynchronisation after a mismatch, then after a forced request
C 0 A5A5A5A5 A5A5A5A5 5A5A5A5A A5A5A5A5
M 2 0 0 1
S 1 0 1 0 0
M 3 7 0 0
S 1 0 0 1 0
M 1 0 0 0
S 1 0 0 0 0
R 10 00000001 0
W 00 00000025
M 2 0 0 1
R 00 00000005 0
S 1 0 1 0 0
M 3 7 0 0
S 1 0 0 1 0
M 1 0 0 0
S 1 0 0 0 0
# Rapid recovery
W 00 00000015
C 1 00000000 00800000 00000000 00000000
M 4 0 0 0
M 4 0 0 0
S 1 0 0 0 1
M 1 0 0 0
S 1 0 0 0 0
R 0C 00000001 0
# Leave lockstep, then three different words in run mode
W 00 00000004
M 0 6 0 0
S 0 0 0 0 0
W 00 00000003
M 1 0 0 0
C 0 0000000F 000000F0 00000F00 00000000
M 1 0 0 0
R 08 00000001 0
R 0C 00000001 0
R 10 00000001 0
